/* Makefile */
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_axi_bridge with Verilator, run it, check sim.log"
	@echo "  clean  remove the build folder and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f sim.f --top-module tb_axi_bridge -Mdir $(BUILD) -o sim
	-./$(BUILD)/sim > sim.log 2>&1
	@cat sim.log
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log

/* axi_bridge_config.svh */
`ifndef AXI_BRIDGE_CONFIG_SVH
`define AXI_BRIDGE_CONFIG_SVH

// AXI bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 128
`define AXI_STRB_W 16 // One bit per data byte
`define AXI_ID_W 4

// Read IDs per client
`define INST_ID 4'h0
`define DATA_ID 4'h1

`endif

/* axi_bridge_pkg.sv */
`default_nettype none

package axi_bridge_pkg;

    // Read channel sequencing
    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_ADDR = 2'd1, // AR held until accepted
        RD_DATA = 2'd2  // Waiting on the R beat
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_SEND = 2'd1, // AW and W in flight
        WR_RESP = 2'd2  // Waiting on B
    } wr_state_e;

    // AXI size field, bytes per beat
    typedef enum logic [2:0] {
        SIZE_1B  = 3'd0,
        SIZE_2B  = 3'd1,
        SIZE_4B  = 3'd2,
        SIZE_16B = 3'd4
    } axi_size_e;

endpackage

`default_nettype wire

/* axi_bridge_top.sv */
`default_nettype none

`include "axi_bridge_config.svh"

module axi_bridge_top
    import client_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n_i,
    // Instruction fetch client
    input  wire                      inst_rd_req_i,
    input  wire [`AXI_ADDR_W-1:0]    inst_rd_addr_i,
    output logic                     inst_rd_rdy_o,
    output logic                     inst_ret_valid_o,
    output logic [`AXI_DATA_W-1:0]   inst_ret_data_o,
    // Data client
    input  wire                      data_rd_req_i,
    input  wire req_type_e           data_rd_type_i,
    input  wire [`AXI_ADDR_W-1:0]    data_rd_addr_i,
    output logic                     data_rd_rdy_o,
    output logic                     data_ret_valid_o,
    output logic [`AXI_DATA_W-1:0]   data_ret_data_o,
    input  wire                      data_wr_req_i,
    input  wire req_type_e           data_wr_type_i,
    input  wire [`AXI_ADDR_W-1:0]    data_wr_addr_i,
    input  wire [`AXI_DATA_W-1:0]    data_wr_data_i,
    input  wire [`AXI_STRB_W-1:0]    data_wr_strb_i,
    output logic                     data_wr_rdy_o,
    // AXI read
    output logic [`AXI_ID_W-1:0]     arid_o,
    output logic [`AXI_ADDR_W-1:0]   araddr_o,
    output logic [2:0]               arsize_o,
    output logic                     arvalid_o,
    input  wire                      arready_i,
    input  wire [`AXI_ID_W-1:0]      rid_i,
    input  wire [`AXI_DATA_W-1:0]    rdata_i,
    input  wire                      rvalid_i,
    output logic                     rready_o,
    // AXI write
    output logic [`AXI_ADDR_W-1:0]   awaddr_o,
    output logic [2:0]               awsize_o,
    output logic                     awvalid_o,
    input  wire                      awready_i,
    output logic [`AXI_DATA_W-1:0]   wdata_o,
    output logic [`AXI_STRB_W-1:0]   wstrb_o,
    output logic                     wvalid_o,
    input  wire                      wready_i,
    input  wire                      bvalid_i,
    output logic                     bready_o
);

    read_return_if ret_if ();
    write_buf_if   wbuf_if ();

    read_arbiter_fsm u_read_arbiter_fsm (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_rd_req_i  (inst_rd_req_i),
        .inst_rd_addr_i (inst_rd_addr_i),
        .data_rd_req_i  (data_rd_req_i),
        .data_rd_type_i (data_rd_type_i),
        .data_rd_addr_i (data_rd_addr_i),
        .arready_i      (arready_i),
        .rid_i          (rid_i),
        .rdata_i        (rdata_i),
        .rvalid_i       (rvalid_i),
        .inst_rd_rdy_o  (inst_rd_rdy_o),
        .data_rd_rdy_o  (data_rd_rdy_o),
        .arid_o         (arid_o),
        .araddr_o       (araddr_o),
        .arsize_o       (arsize_o),
        .arvalid_o      (arvalid_o),
        .rready_o       (rready_o),
        .ret            (ret_if.source)
    );

    read_return_router u_read_return_router (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .ret              (ret_if.sink),
        .inst_ret_valid_o (inst_ret_valid_o),
        .inst_ret_data_o  (inst_ret_data_o),
        .data_ret_valid_o (data_ret_valid_o),
        .data_ret_data_o  (data_ret_data_o)
    );

    write_fsm u_write_fsm (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .data_wr_req_i (data_wr_req_i),
        .awready_i     (awready_i),
        .wready_i      (wready_i),
        .bvalid_i      (bvalid_i),
        .data_wr_rdy_o (data_wr_rdy_o),
        .awaddr_o      (awaddr_o),
        .awsize_o      (awsize_o),
        .awvalid_o     (awvalid_o),
        .wdata_o       (wdata_o),
        .wstrb_o       (wstrb_o),
        .wvalid_o      (wvalid_o),
        .bready_o      (bready_o),
        .wr_buf        (wbuf_if.control)
    );

    write_data_buffer u_write_data_buffer (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .data_wr_type_i (data_wr_type_i),
        .data_wr_addr_i (data_wr_addr_i),
        .data_wr_data_i (data_wr_data_i),
        .data_wr_strb_i (data_wr_strb_i),
        .wr_buf         (wbuf_if.storage)
    );

endmodule

`default_nettype wire

/* bridge_ifs.sv */
`default_nettype none

`include "axi_bridge_config.svh"

// R beat handed from the read FSM to the return router
interface read_return_if
    import client_pkg::*;
();
    logic                   beat_fire; // One cycle per accepted beat
    logic [`AXI_ID_W-1:0]   beat_id;
    logic [`AXI_DATA_W-1:0] beat_data;
    client_e                owner;     // Client granted for this read

    modport source (output beat_fire, beat_id, beat_data, owner);
    modport sink   (input  beat_fire, beat_id, beat_data, owner);
endinterface

// Write payload held while AW and W are pending
interface write_buf_if
    import axi_bridge_pkg::*;
();
    logic                     load;
    logic [`AXI_ADDR_W-1:0]   addr;
    logic [`AXI_DATA_W-1:0]   data;
    logic [`AXI_STRB_W-1:0]   strb;
    axi_size_e                size;

    modport control (output load, input  addr, data, strb, size);
    modport storage (input  load, output addr, data, strb, size);
endinterface

`default_nettype wire

/* client_pkg.sv */
`default_nettype none

package client_pkg;

    // Same codes as the AXI size field
    typedef enum logic [2:0] {
        REQ_BYTE = 3'd0,
        REQ_HALF = 3'd1,
        REQ_WORD = 3'd2,
        REQ_LINE = 3'd4  // Full 128-bit line
    } req_type_e;

    typedef enum logic {
        CLIENT_INST = 1'b0,
        CLIENT_DATA = 1'b1
    } client_e;

endpackage

`default_nettype wire

/* read_arbiter_fsm.sv */
`default_nettype none

`include "axi_bridge_config.svh"

module read_arbiter_fsm
    import axi_bridge_pkg::*;
    import client_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      inst_rd_req_i,
    input  wire [`AXI_ADDR_W-1:0]    inst_rd_addr_i,
    input  wire                      data_rd_req_i,
    input  wire req_type_e           data_rd_type_i,
    input  wire [`AXI_ADDR_W-1:0]    data_rd_addr_i,
    input  wire                      arready_i,
    input  wire [`AXI_ID_W-1:0]      rid_i,
    input  wire [`AXI_DATA_W-1:0]    rdata_i,
    input  wire                      rvalid_i,
    output logic                     inst_rd_rdy_o,
    output logic                     data_rd_rdy_o,
    output logic [`AXI_ID_W-1:0]     arid_o,
    output logic [`AXI_ADDR_W-1:0]   araddr_o,
    output axi_size_e                arsize_o,
    output logic                     arvalid_o,
    output logic                     rready_o,
    read_return_if.source            ret
);

    rd_state_e              state_q;
    client_e                owner_q;
    logic [`AXI_ADDR_W-1:0] addr_q;
    axi_size_e              size_q;
    logic                   data_acc;
    logic                   inst_acc;

    // Data client wins a tie
    assign data_rd_rdy_o = (state_q == RD_IDLE);
    assign inst_rd_rdy_o = (state_q == RD_IDLE) && !data_rd_req_i;
    assign data_acc      = data_rd_req_i && data_rd_rdy_o;
    assign inst_acc      = inst_rd_req_i && inst_rd_rdy_o;

    assign arvalid_o = (state_q == RD_ADDR);
    assign rready_o  = (state_q == RD_DATA);
    assign araddr_o  = addr_q;
    assign arsize_o  = size_q;
    assign arid_o    = (owner_q == CLIENT_DATA) ? `DATA_ID : `INST_ID;

    assign ret.beat_fire = rvalid_i && rready_o;
    assign ret.beat_id   = rid_i;
    assign ret.beat_data = rdata_i;
    assign ret.owner     = owner_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= RD_IDLE;
            owner_q <= CLIENT_INST;
        end else begin
            case (state_q)
                RD_IDLE: if (data_acc || inst_acc) state_q <= RD_ADDR;
                RD_ADDR: if (arready_i) state_q <= RD_DATA;
                RD_DATA: if (rvalid_i) state_q <= RD_IDLE; // Free again on the R beat
                default: state_q <= RD_IDLE;
            endcase
            if (data_acc) begin
                owner_q <= CLIENT_DATA;
            end else if (inst_acc) begin
                owner_q <= CLIENT_INST;
            end
        end
    end

    // Granted request payload
    always_ff @(posedge clk) begin
        if (data_acc) begin
            addr_q <= data_rd_addr_i;
            size_q <= axi_size_e'(data_rd_type_i);
        end else if (inst_acc) begin
            addr_q <= inst_rd_addr_i;
            size_q <= SIZE_16B; // Fetch is always a full line
        end
    end

endmodule

`default_nettype wire

/* read_return_router.sv */
`default_nettype none

`include "axi_bridge_config.svh"

module read_return_router
    import client_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n_i,
    read_return_if.sink              ret,
    output logic                     inst_ret_valid_o,
    output logic [`AXI_DATA_W-1:0]   inst_ret_data_o,
    output logic                     data_ret_valid_o,
    output logic [`AXI_DATA_W-1:0]   data_ret_data_o
);

    client_e dst;

    // Destination follows the R channel ID
    assign dst = (ret.beat_id == `DATA_ID) ? CLIENT_DATA : CLIENT_INST;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_ret_valid_o <= 1'b0;
            data_ret_valid_o <= 1'b0;
        end else begin
            inst_ret_valid_o <= ret.beat_fire && (dst == CLIENT_INST);
            data_ret_valid_o <= ret.beat_fire && (dst == CLIENT_DATA);
        end
    end

    // Other client keeps its last line
    always_ff @(posedge clk) begin
        if (ret.beat_fire && dst == CLIENT_INST) inst_ret_data_o <= ret.beat_data;
        if (ret.beat_fire && dst == CLIENT_DATA) data_ret_data_o <= ret.beat_data;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
axi_bridge_pkg.sv
client_pkg.sv
bridge_ifs.sv
read_arbiter_fsm.sv
read_return_router.sv
write_fsm.sv
write_data_buffer.sv
axi_bridge_top.sv
tb_axi_slave_mem.sv
tb_axi_bridge.sv

/* tb_axi_bridge.sv */
`default_nettype none

`include "axi_bridge_config.svh"

module tb_axi_bridge
    import client_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Five tasks of up to 40 transfers, each within 10 cycles
    localparam int unsigned MAX_CYCLES = 2000;

    logic                   clk;
    logic                   rst_n_i;
    logic                   inst_rd_req_i;
    logic [`AXI_ADDR_W-1:0] inst_rd_addr_i;
    logic                   inst_rd_rdy_o;
    logic                   inst_ret_valid_o;
    logic [`AXI_DATA_W-1:0] inst_ret_data_o;
    logic                   data_rd_req_i;
    req_type_e              data_rd_type_i;
    logic [`AXI_ADDR_W-1:0] data_rd_addr_i;
    logic                   data_rd_rdy_o;
    logic                   data_ret_valid_o;
    logic [`AXI_DATA_W-1:0] data_ret_data_o;
    logic                   data_wr_req_i;
    req_type_e              data_wr_type_i;
    logic [`AXI_ADDR_W-1:0] data_wr_addr_i;
    logic [`AXI_DATA_W-1:0] data_wr_data_i;
    logic [`AXI_STRB_W-1:0] data_wr_strb_i;
    logic                   data_wr_rdy_o;
    logic [`AXI_ID_W-1:0]   arid_o;
    logic [`AXI_ADDR_W-1:0] araddr_o;
    logic [2:0]             arsize_o;
    logic                   arvalid_o;
    logic                   arready_i;
    logic [`AXI_ID_W-1:0]   rid_i;
    logic [`AXI_DATA_W-1:0] rdata_i;
    logic                   rvalid_i;
    logic                   rready_o;
    logic [`AXI_ADDR_W-1:0] awaddr_o;
    logic [2:0]             awsize_o;
    logic                   awvalid_o;
    logic                   awready_i;
    logic [`AXI_DATA_W-1:0] wdata_o;
    logic [`AXI_STRB_W-1:0] wstrb_o;
    logic                   wvalid_o;
    logic                   wready_i;
    logic                   bvalid_i;
    logic                   bready_o;

    logic [`AXI_DATA_W-1:0] model [64]; // Expected memory contents
    int unsigned            inst_ret_cnt = 0;
    int unsigned            data_ret_cnt = 0;
    int unsigned            cycle_cnt = 0;

    axi_bridge_top dut (.*);

    tb_axi_slave_mem u_mem (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .arid_i    (arid_o),
        .araddr_i  (araddr_o),
        .arvalid_i (arvalid_o),
        .arready_o (arready_i),
        .rid_o     (rid_i),
        .rdata_o   (rdata_i),
        .rvalid_o  (rvalid_i),
        .rready_i  (rready_o),
        .awaddr_i  (awaddr_o),
        .awvalid_i (awvalid_o),
        .awready_o (awready_i),
        .wdata_i   (wdata_o),
        .wstrb_i   (wstrb_o),
        .wvalid_i  (wvalid_o),
        .wready_o  (wready_i),
        .bvalid_o  (bvalid_i),
        .bready_i  (bready_o)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (inst_ret_valid_o) inst_ret_cnt <= inst_ret_cnt + 1;
        if (data_ret_valid_o) data_ret_cnt <= data_ret_cnt + 1;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles, a transfer never finished", cycle_cnt));
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // AXI size code for each request width
    function automatic logic [2:0] size_code(input req_type_e t);
        case (t)
            REQ_BYTE: return 3'd0;
            REQ_HALF: return 3'd1;
            REQ_WORD: return 3'd2;
            default:  return 3'd4;
        endcase
    endfunction

    function automatic req_type_e pick_type();
        case ($urandom_range(3, 0))
            0:       return REQ_BYTE;
            1:       return REQ_HALF;
            2:       return REQ_WORD;
            default: return REQ_LINE;
        endcase
    endfunction

    function automatic logic [127:0] rand_data();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // Follows AR from valid to handshake, payload must not move
    task automatic wait_ar(input logic [3:0] id, input logic [31:0] addr,
                           input logic [2:0] size);
        @(negedge clk);
        while (!arvalid_o) @(negedge clk);
        forever begin
            check_val("arvalid_o", 128'(arvalid_o), 128'd1);
            check_val("arid_o", 128'(arid_o), 128'(id));
            check_val("araddr_o", 128'(araddr_o), 128'(addr));
            check_val("arsize_o", 128'(arsize_o), 128'(size));
            if (arready_i) break;
            @(negedge clk);
        end
    endtask

    task automatic wait_ret(input logic is_inst, input logic [127:0] exp);
        @(negedge clk);
        while (!(is_inst ? inst_ret_valid_o : data_ret_valid_o)) @(negedge clk);
        if (is_inst) check_val("inst_ret_data_o", inst_ret_data_o, exp);
        else check_val("data_ret_data_o", data_ret_data_o, exp);
    endtask

    task automatic read_line(input logic is_inst, input req_type_e t, input logic [31:0] addr);
        int unsigned n_i;
        int unsigned n_d;
        n_i = inst_ret_cnt;
        n_d = data_ret_cnt;
        @(posedge clk);
        if (is_inst) begin
            inst_rd_req_i  <= 1'b1;
            inst_rd_addr_i <= addr;
        end else begin
            data_rd_req_i  <= 1'b1;
            data_rd_type_i <= t;
            data_rd_addr_i <= addr;
        end
        @(negedge clk);
        while (!(is_inst ? inst_rd_rdy_o : data_rd_rdy_o)) @(negedge clk);
        @(posedge clk);
        inst_rd_req_i <= 1'b0;
        data_rd_req_i <= 1'b0;
        wait_ar(is_inst ? `INST_ID : `DATA_ID, addr, is_inst ? 3'd4 : size_code(t));
        wait_ret(is_inst, model[addr[9:4]]);
        repeat (2) @(negedge clk);
        check_val("inst_ret_valid_o pulses", 128'(inst_ret_cnt - n_i), is_inst ? 128'd1 : 128'd0);
        check_val("data_ret_valid_o pulses", 128'(data_ret_cnt - n_d), is_inst ? 128'd0 : 128'd1);
    endtask

    task automatic write_line(input req_type_e t, input logic [31:0] addr,
                              input logic [127:0] data, input logic [15:0] strb);
        bit aw_seen;
        bit w_seen;
        bit b_seen;
        aw_seen = 1'b0;
        w_seen  = 1'b0;
        b_seen  = 1'b0;
        @(posedge clk);
        data_wr_req_i  <= 1'b1;
        data_wr_type_i <= t;
        data_wr_addr_i <= addr;
        data_wr_data_i <= data;
        data_wr_strb_i <= strb;
        @(negedge clk);
        while (!data_wr_rdy_o) @(negedge clk);
        @(posedge clk);
        data_wr_req_i <= 1'b0;
        @(negedge clk);
        while (!(aw_seen && w_seen)) begin
            if (!aw_seen) begin
                check_val("awvalid_o", 128'(awvalid_o), 128'd1);
                check_val("awaddr_o", 128'(awaddr_o), 128'(addr));
                check_val("awsize_o", 128'(awsize_o), 128'(size_code(t)));
                aw_seen = awready_i;
            end
            if (!w_seen) begin
                check_val("wvalid_o", 128'(wvalid_o), 128'd1);
                check_val("wdata_o", wdata_o, data);
                check_val("wstrb_o", 128'(wstrb_o), 128'(strb));
                w_seen = wready_i;
            end
            @(negedge clk);
        end
        while (!data_wr_rdy_o) begin
            if (bvalid_i && bready_o) b_seen = 1'b1;
            @(negedge clk);
        end
        assert (b_seen) else fail_run("data_wr_rdy_o rose before the B handshake");
        for (int b = 0; b < `AXI_STRB_W; b++) begin
            if (strb[b]) model[addr[9:4]][8*b +: 8] = data[8*b +: 8];
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_val("arvalid_o", 128'(arvalid_o), 128'd0);
        check_val("awvalid_o", 128'(awvalid_o), 128'd0);
        check_val("wvalid_o", 128'(wvalid_o), 128'd0);
        check_val("rready_o", 128'(rready_o), 128'd0);
        check_val("bready_o", 128'(bready_o), 128'd0);
        check_val("inst_ret_valid_o", 128'(inst_ret_valid_o), 128'd0);
        check_val("data_ret_valid_o", 128'(data_ret_valid_o), 128'd0);
        check_val("inst_rd_rdy_o", 128'(inst_rd_rdy_o), 128'd1);
        check_val("data_rd_rdy_o", 128'(data_rd_rdy_o), 128'd1);
        check_val("data_wr_rdy_o", 128'(data_wr_rdy_o), 128'd1);
    endtask

    task automatic data_reads_all_types();
        req_type_e types [4];
        types = '{REQ_BYTE, REQ_HALF, REQ_WORD, REQ_LINE};
        foreach (types[i]) begin
            read_line(1'b0, types[i], $urandom);
            read_line(1'b0, types[i], $urandom);
        end
    endtask

    // Data wins the tie, fetch stays pending and runs next
    task automatic both_clients_read();
        logic [31:0] ia;
        logic [31:0] da;
        ia = $urandom;
        da = $urandom;
        @(posedge clk);
        inst_rd_req_i  <= 1'b1;
        inst_rd_addr_i <= ia;
        data_rd_req_i  <= 1'b1;
        data_rd_type_i <= REQ_LINE;
        data_rd_addr_i <= da;
        @(negedge clk);
        check_val("inst_rd_rdy_o", 128'(inst_rd_rdy_o), 128'd0);
        check_val("data_rd_rdy_o", 128'(data_rd_rdy_o), 128'd1);
        @(posedge clk);
        data_rd_req_i <= 1'b0;
        wait_ar(`DATA_ID, da, 3'd4);
        wait_ret(1'b0, model[da[9:4]]);
        while (!inst_rd_rdy_o) @(negedge clk);
        @(posedge clk);
        inst_rd_req_i <= 1'b0;
        wait_ar(`INST_ID, ia, 3'd4);
        wait_ret(1'b1, model[ia[9:4]]);
    endtask

    task automatic write_read_back();
        logic [31:0] addr;
        repeat (4) begin
            addr = $urandom;
            write_line(pick_type(), addr, rand_data(), 16'($urandom));
            read_line(1'b0, pick_type(), addr);
        end
    endtask

    task automatic mixed_traffic(input int unsigned count);
        repeat (count) begin
            case ($urandom_range(2, 0))
                0:       read_line(1'b1, REQ_LINE, $urandom);
                1:       read_line(1'b0, pick_type(), $urandom);
                default: write_line(pick_type(), $urandom, rand_data(), 16'($urandom));
            endcase
        end
    endtask

    initial begin
        void'($urandom(32'hc7b3_3963));
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        inst_rd_req_i  = 1'b0;
        inst_rd_addr_i = '0;
        data_rd_req_i  = 1'b0;
        data_rd_type_i = REQ_WORD;
        data_rd_addr_i = '0;
        data_wr_req_i  = 1'b0;
        data_wr_type_i = REQ_WORD;
        data_wr_addr_i = '0;
        data_wr_data_i = '0;
        data_wr_strb_i = '0;
        for (int i = 0; i < 64; i++) begin
            model[i] = {4{32'(i) ^ 32'ha5a5_0000}}; // Same fill as the slave line
        end
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        check_reset_state();
        repeat (8) read_line(1'b1, REQ_LINE, $urandom);
        data_reads_all_types();
        both_clients_read();
        write_read_back();
        mixed_traffic(40);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_axi_slave_mem.sv */
`default_nettype none

`include "axi_bridge_config.svh"

module tb_axi_slave_mem (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire [`AXI_ID_W-1:0]    arid_i,
    input  wire [`AXI_ADDR_W-1:0]  araddr_i,
    input  wire                    arvalid_i,
    output logic                   arready_o,
    output logic [`AXI_ID_W-1:0]   rid_o,
    output logic [`AXI_DATA_W-1:0] rdata_o,
    output logic                   rvalid_o,
    input  wire                    rready_i,
    input  wire [`AXI_ADDR_W-1:0]  awaddr_i,
    input  wire                    awvalid_i,
    output logic                   awready_o,
    input  wire [`AXI_DATA_W-1:0]  wdata_i,
    input  wire [`AXI_STRB_W-1:0]  wstrb_i,
    input  wire                    wvalid_i,
    output logic                   wready_o,
    output logic                   bvalid_o,
    input  wire                    bready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`AXI_DATA_W-1:0] mem [64]; // Indexed by address bits [9:4]
    logic [`AXI_DATA_W-1:0] w_data_q;
    logic [`AXI_STRB_W-1:0] w_strb_q;
    logic [5:0]             aw_line_q;
    logic                   aw_have_q;
    logic                   w_have_q;
    logic                   r_pend_q;  // AR taken, R beat not yet sent
    int unsigned            ar_wait;
    int unsigned            r_wait;
    int unsigned            aw_wait;
    int unsigned            w_wait;

    initial begin
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rid_o     = '0;
        rdata_o   = '0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {4{32'(i) ^ 32'ha5a5_0000}};
        end
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            aw_have_q <= 1'b0;
            w_have_q  <= 1'b0;
            r_pend_q  <= 1'b0;
            ar_wait   <= 0;
            aw_wait   <= 0;
            w_wait    <= 0;
        end else begin
            // Read address, ready after 0 to 3 cycles
            arready_o <= 1'b0;
            if (arvalid_i && arready_o) begin
                rid_o    <= arid_i;
                rdata_o  <= mem[araddr_i[9:4]];
                r_pend_q <= 1'b1;
                r_wait   <= $urandom_range(3, 0);
                ar_wait  <= $urandom_range(3, 0);
            end else if (arvalid_i) begin
                if (ar_wait == 0) arready_o <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
                r_pend_q <= 1'b0;
            end else if (r_pend_q && !rvalid_o) begin
                if (r_wait == 0) rvalid_o <= 1'b1;
                else r_wait <= r_wait - 1;
            end
            // Write address and data channels
            awready_o <= 1'b0;
            if (awvalid_i && awready_o) begin
                aw_have_q <= 1'b1;
                aw_line_q <= awaddr_i[9:4];
                aw_wait   <= $urandom_range(3, 0);
            end else if (awvalid_i) begin
                if (aw_wait == 0) awready_o <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end
            wready_o <= 1'b0;
            if (wvalid_i && wready_o) begin
                w_have_q <= 1'b1;
                w_data_q <= wdata_i;
                w_strb_q <= wstrb_i;
                w_wait   <= $urandom_range(3, 0);
            end else if (wvalid_i) begin
                if (w_wait == 0) wready_o <= 1'b1;
                else w_wait <= w_wait - 1;
            end
            if (bvalid_o && bready_i) begin
                bvalid_o  <= 1'b0;
                aw_have_q <= 1'b0;
                w_have_q  <= 1'b0;
            end else if (aw_have_q && w_have_q && !bvalid_o) begin
                for (int b = 0; b < `AXI_STRB_W; b++) begin
                    if (w_strb_q[b]) mem[aw_line_q][8*b +: 8] <= w_data_q[8*b +: 8];
                end
                bvalid_o <= 1'b1; // Line already merged when B goes out
            end
        end
    end

endmodule

`default_nettype wire

/* write_data_buffer.sv */
`default_nettype none

`include "axi_bridge_config.svh"

module write_data_buffer
    import axi_bridge_pkg::*;
    import client_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire req_type_e           data_wr_type_i,
    input  wire [`AXI_ADDR_W-1:0]    data_wr_addr_i,
    input  wire [`AXI_DATA_W-1:0]    data_wr_data_i,
    input  wire [`AXI_STRB_W-1:0]    data_wr_strb_i,
    write_buf_if.storage             wr_buf
);

    // No bytes enabled until the first write
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_buf.strb <= '0;
            wr_buf.size <= SIZE_1B;
        end else if (wr_buf.load) begin
            wr_buf.strb <= data_wr_strb_i;
            wr_buf.size <= axi_size_e'(data_wr_type_i); // Codes line up one to one
        end
    end

    // Held through any AW or W stall
    always_ff @(posedge clk) begin
        if (wr_buf.load) begin
            wr_buf.addr <= data_wr_addr_i;
            wr_buf.data <= data_wr_data_i;
        end
    end

endmodule

`default_nettype wire

/* write_fsm.sv */
`default_nettype none

`include "axi_bridge_config.svh"

module write_fsm
    import axi_bridge_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      data_wr_req_i,
    input  wire                      awready_i,
    input  wire                      wready_i,
    input  wire                      bvalid_i,
    output logic                     data_wr_rdy_o,
    output logic [`AXI_ADDR_W-1:0]   awaddr_o,
    output axi_size_e                awsize_o,
    output logic                     awvalid_o,
    output logic [`AXI_DATA_W-1:0]   wdata_o,
    output logic [`AXI_STRB_W-1:0]   wstrb_o,
    output logic                     wvalid_o,
    output logic                     bready_o,
    write_buf_if.control             wr_buf
);

    wr_state_e state_q;
    logic      aw_done_q; // AW already accepted
    logic      w_done_q;  // W already accepted
    logic      aw_fire;
    logic      w_fire;

    assign data_wr_rdy_o = (state_q == WR_IDLE);
    assign wr_buf.load   = data_wr_req_i && data_wr_rdy_o;

    assign awvalid_o = (state_q == WR_SEND) && !aw_done_q;
    assign wvalid_o  = (state_q == WR_SEND) && !w_done_q;
    assign bready_o  = (state_q == WR_RESP);
    assign aw_fire   = awvalid_o && awready_i;
    assign w_fire    = wvalid_o && wready_i;

    assign awaddr_o = wr_buf.addr;
    assign awsize_o = wr_buf.size;
    assign wdata_o  = wr_buf.data;
    assign wstrb_o  = wr_buf.strb;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= WR_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    aw_done_q <= 1'b0;
                    w_done_q  <= 1'b0;
                    if (wr_buf.load) state_q <= WR_SEND;
                end
                WR_SEND: begin
                    aw_done_q <= aw_done_q || aw_fire;
                    w_done_q  <= w_done_q || w_fire;
                    // Channels may finish in either order
                    if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) state_q <= WR_RESP;
                end
                WR_RESP: if (bvalid_i) state_q <= WR_IDLE;
                default: state_q <= WR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire
